// File: hw/cdbus_pkg.sv
// CDBUS controller shared definitions
// Register map, version code, setting register layout and the
// Modbus CRC-16 step used on both the receive and transmit paths
package cdbus_pkg;

    localparam logic [4:0] reg_version       = 5'h00;
    localparam logic [4:0] reg_setting       = 5'h01;
    localparam logic [4:0] reg_idle_wait_len = 5'h02;
    localparam logic [4:0] reg_tx_wait_len   = 5'h03;
    localparam logic [4:0] reg_filter        = 5'h04;
    localparam logic [4:0] reg_div_l         = 5'h05;
    localparam logic [4:0] reg_div_h         = 5'h06;
    localparam logic [4:0] reg_int_flag      = 5'h09;
    localparam logic [4:0] reg_int_mask      = 5'h0a;
    localparam logic [4:0] reg_rx            = 5'h0b;
    localparam logic [4:0] reg_tx            = 5'h0c;
    localparam logic [4:0] reg_rx_ctrl       = 5'h0d;
    localparam logic [4:0] reg_tx_ctrl       = 5'h0e;
    localparam logic [4:0] reg_rx_addr       = 5'h0f;

    localparam logic [7:0] cdbus_version = 8'h08;

    // Writable bits of the setting byte
    localparam logic [7:0] setting_mask = 8'h81;

    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic       full_duplex;
            logic [5:0] rsvd;
            logic       tx_push_pull;
        } f;
    } setting_t;

    // One byte of reflected CRC-16, poly 0xA001, init 0xFFFF
    function automatic logic [15:0] crc16_next(input logic [15:0] crc,
                                               input logic [7:0]  data);
        logic [15:0] c;
        c = crc ^ {8'h00, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 16'ha001) : (c >> 1);
        end
        return c;
    endfunction

endpackage

// File: hw/pp_ram.sv
// Multi-page byte memory
// The writer fills its current page and commits it on a switch pulse;
// the reader drains committed pages oldest first and frees them
`timescale 1ns/100ps

module pp_ram #(
    parameter int page_bits = 1
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic [7:0] wr_byte,
    input  logic [7:0] wr_addr,
    input  logic       wr_en,
    input  logic       switch,
    input  logic [7:0] rd_addr,
    input  logic       rd_done,
    input  logic       rd_done_all,
    output logic [7:0] rd_byte,
    output logic       unread,
    output logic       switch_fail
);

    localparam logic [page_bits:0] pages = 1 << page_bits;

    logic [7:0]           mem [0:(256 << page_bits)-1];
    logic [page_bits-1:0] wr_page;
    logic [page_bits-1:0] rd_page;
    logic [page_bits:0]   count;
    logic                 full;
    logic                 commit;
    logic                 free;

    // When all pages hold committed frames the writer page aliases the oldest one
    assign full    = (count == pages);
    assign commit  = switch && !full;
    assign free    = rd_done && unread;
    assign unread  = (count != '0);
    assign rd_byte = mem[{rd_page, rd_addr}];

    always_ff @(posedge clk) begin
        if (wr_en && !full)
            mem[{wr_page, wr_addr}] <= wr_byte;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_page     <= '0;
            rd_page     <= '0;
            count       <= '0;
            switch_fail <= 1'b0;
        end else begin
            switch_fail <= switch && full && !rd_done_all;
            if (rd_done_all) begin
                rd_page <= wr_page;
                count   <= '0;
            end else begin
                if (commit)
                    wr_page <= wr_page + 1'b1;
                if (free)
                    rd_page <= rd_page + 1'b1;
                count <= count + (page_bits + 1)'(commit) - (page_bits + 1)'(free);
            end
        end
    end

endmodule

// File: hw/rx_des.sv
// UART-style receive deserializer
// Detects the start edge, samples each bit at mid-bit and shifts it in
// LSB first; counts idle bit-times after the stop bit to flag bus idle
`timescale 1ns/100ps

module rx_des (
    input  logic        clk,
    input  logic        reset_n,
    input  logic [15:0] div,
    input  logic [7:0]  idle_wait_len,
    input  logic        rx,
    input  logic        force_wait_idle,
    output logic [7:0]  data,
    output logic        data_clk,
    output logic        bus_idle,
    output logic        bit_inc
);

    logic        rx_d;
    logic        busy;
    logic [15:0] cnt;
    logic [3:0]  bit_idx;
    logic [7:0]  idle_cnt;
    logic        mid;
    logic        tick;

    assign mid  = (cnt == {1'b0, div[15:1]});
    assign tick = (cnt == div);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_d     <= 1'b1;
            busy     <= 1'b0;
            cnt      <= 16'd0;
            bit_idx  <= 4'd0;
            idle_cnt <= 8'd0;
            data     <= 8'd0;
            data_clk <= 1'b0;
            bus_idle <= 1'b0;
            bit_inc  <= 1'b0;
        end else begin
            rx_d     <= rx;
            data_clk <= 1'b0;
            bit_inc  <= 1'b0;
            cnt      <= tick ? 16'd0 : cnt + 16'd1;

            if (!busy && rx_d && !rx) begin
                busy     <= 1'b1;
                cnt      <= 16'd0;
                bit_idx  <= 4'd0;
                idle_cnt <= 8'd0;
                bus_idle <= 1'b0;
            end else if (busy) begin
                if (tick)
                    bit_idx <= bit_idx + 4'd1;
                if (mid) begin
                    if (bit_idx == 4'd0 && rx) begin
                        busy <= 1'b0;   // glitch, not a start bit
                    end else if (bit_idx == 4'd9) begin
                        busy     <= 1'b0;
                        cnt      <= 16'd0;
                        data_clk <= !force_wait_idle;
                    end else if (bit_idx != 4'd0) begin
                        data <= {rx, data[7:1]};
                    end
                end
            end else if (tick) begin
                // Idle bit-time
                bit_inc <= 1'b1;
                if (idle_cnt != 8'hff)
                    idle_cnt <= idle_cnt + 8'd1;
                if ({1'b0, idle_cnt} + 9'd1 >= {1'b0, idle_wait_len})
                    bus_idle <= 1'b1;
            end
        end
    end

endmodule

// File: hw/rx_bytes.sv
// Receive frame assembler
// Writes incoming bytes into the receive page, filters on destination,
// runs the CRC and commits or rejects the frame once the bus goes idle
`timescale 1ns/100ps

module rx_bytes
    import cdbus_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic [7:0] filter,
    input  logic       abort,
    input  logic       bus_idle,
    input  logic [7:0] data,
    input  logic       data_clk,
    output logic [7:0] ram_wr_byte,
    output logic [7:0] ram_wr_addr,
    output logic       ram_wr_en,
    output logic       ram_switch,
    output logic       error,
    output logic       force_wait_idle
);

    logic [8:0]  byte_cnt;
    logic [7:0]  len;
    logic [15:0] crc;
    logic        bus_idle_d;
    logic        dst_ok;
    logic        frame_ok;

    assign ram_wr_byte = data;
    assign ram_wr_addr = byte_cnt[7:0];
    assign ram_wr_en   = data_clk && !byte_cnt[8];

    assign dst_ok = (data == filter) || (data == 8'hff) || (filter == 8'hff);

    // Running CRC over data plus its own CRC bytes leaves zero
    assign frame_ok = (byte_cnt >= 9'd5) && (byte_cnt == {1'b0, len} + 9'd5)
                      && (crc == 16'h0000);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            byte_cnt        <= 9'd0;
            len             <= 8'd0;
            crc             <= 16'hffff;
            bus_idle_d      <= 1'b0;
            ram_switch      <= 1'b0;
            error           <= 1'b0;
            force_wait_idle <= 1'b0;
        end else begin
            bus_idle_d <= bus_idle;
            ram_switch <= 1'b0;
            error      <= 1'b0;

            if (abort) begin
                byte_cnt        <= 9'd0;
                crc             <= 16'hffff;
                force_wait_idle <= !bus_idle;   // drop the tail of a frame in flight
            end else if (bus_idle && !bus_idle_d) begin
                if (!force_wait_idle && byte_cnt != 9'd0) begin
                    ram_switch <= frame_ok;
                    error      <= !frame_ok;
                end
                byte_cnt        <= 9'd0;
                crc             <= 16'hffff;
                force_wait_idle <= 1'b0;
            end else if (data_clk) begin
                crc <= crc16_next(crc, data);
                if (!byte_cnt[8])
                    byte_cnt <= byte_cnt + 9'd1;
                if (byte_cnt == 9'd1 && !dst_ok)
                    force_wait_idle <= 1'b1;
                if (byte_cnt == 9'd2)
                    len <= data;
            end
        end
    end

endmodule

// File: hw/tx_bytes_ser.sv
// Transmit serializer
// Waits for bus idle, sends the oldest transmit page byte by byte with
// start and stop bits, appends the CRC-16 and frees the page when done
`timescale 1ns/100ps

module tx_bytes_ser
    import cdbus_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic [15:0] div,
    input  logic [7:0]  tx_wait_len,
    input  logic        full_duplex,
    input  logic        abort,
    input  logic        bus_idle,
    input  logic        rx_bit_inc,
    input  logic        ram_unread,
    input  logic [7:0]  ram_rd_byte,
    output logic [7:0]  ram_rd_addr,
    output logic        ram_rd_done,
    output logic        tx,
    output logic        tx_en
);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_load  = 2'd1;
    localparam logic [1:0] st_shift = 2'd2;
    localparam logic [1:0] st_done  = 2'd3;

    logic [1:0]  state;
    logic [15:0] cnt;
    logic [3:0]  bit_cnt;
    logic [9:0]  shreg;
    logic [8:0]  idx;
    logic [7:0]  len;
    logic [15:0] crc;
    logic [7:0]  wait_cnt;
    logic        start;
    logic        data_phase;
    logic [7:0]  next_byte;

    assign ram_rd_addr = idx[7:0];
    assign ram_rd_done = (state == st_done) || (abort && ram_unread);
    assign tx          = (state == st_shift) ? shreg[0] : 1'b1;
    assign tx_en       = (state == st_load) || (state == st_shift);
    assign start       = ram_unread && (full_duplex || (bus_idle && wait_cnt >= tx_wait_len));

    // Header bytes come before len is known
    assign data_phase = (idx < 9'd3) || (idx < {1'b0, len} + 9'd3);
    assign next_byte  = data_phase ? ram_rd_byte :
                        (idx == {1'b0, len} + 9'd3) ? crc[7:0] : crc[15:8];

    // Idle bit-times seen before a frame may start
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            wait_cnt <= 8'd0;
        else if (!bus_idle || state != st_idle)
            wait_cnt <= 8'd0;
        else if (rx_bit_inc && wait_cnt != 8'hff)
            wait_cnt <= wait_cnt + 8'd1;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= st_idle;
            cnt     <= 16'd0;
            bit_cnt <= 4'd0;
            shreg   <= 10'h3ff;
            idx     <= 9'd0;
            len     <= 8'd0;
            crc     <= 16'hffff;
        end else if (abort) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    idx <= 9'd0;
                    crc <= 16'hffff;
                    if (start)
                        state <= st_load;
                end
                st_load: begin
                    shreg   <= {1'b1, next_byte, 1'b0};
                    cnt     <= 16'd0;
                    bit_cnt <= 4'd0;
                    if (data_phase)
                        crc <= crc16_next(crc, ram_rd_byte);
                    if (idx == 9'd2)
                        len <= ram_rd_byte;
                    state <= st_shift;
                end
                st_shift: begin
                    if (cnt == div) begin
                        cnt     <= 16'd0;
                        shreg   <= {1'b1, shreg[9:1]};
                        bit_cnt <= bit_cnt + 4'd1;
                        if (bit_cnt == 4'd9) begin
                            idx   <= idx + 9'd1;
                            state <= (idx == {1'b0, len} + 9'd4) ? st_done : st_load;
                        end
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

// File: hw/cdbus.sv
// CDBUS serial bus controller, top level
// Holds the register file and interrupt logic, and ties together the
// receive path (deserializer, frame assembler, page memory) and the
// transmit path (page memory, serializer)
`timescale 1ns/100ps

module cdbus
    import cdbus_pkg::*;
#(
    parameter logic [15:0] div_default  = 16'd346,
    parameter int          rx_page_bits = 2,
    parameter int          tx_page_bits = 1
) (
    input  logic       clk,
    input  logic       reset_n,
    input  logic [4:0] csr_address,
    input  logic       csr_read,
    output logic [7:0] csr_readdata,
    input  logic       csr_write,
    input  logic [7:0] csr_writedata,
    output logic       irq,
    input  logic       rx,
    output logic       tx,
    output logic       tx_en
);

    setting_t    setting;
    logic [7:0]  idle_wait_len;
    logic [7:0]  tx_wait_len;
    logic [7:0]  filter;
    logic [15:0] div;
    logic [4:0]  int_mask;
    logic [4:0]  int_flag;
    logic        rx_error_flag;
    logic        rx_lost_flag;
    logic        rx_meta;
    logic        rx_sync;

    logic        bus_idle;
    logic        rx_bit_inc;
    logic        rx_pending;
    logic        tx_pending;
    logic [7:0]  des_data;
    logic        des_data_clk;
    logic        force_wait_idle;

    logic [7:0]  rx_ram_rd_byte;
    logic [7:0]  rx_ram_rd_addr;
    logic        rx_ram_rd_done;
    logic        rx_clean_all;
    logic [7:0]  rx_ram_wr_byte;
    logic [7:0]  rx_ram_wr_addr;
    logic        rx_ram_wr_en;
    logic        rx_ram_switch;
    logic        rx_ram_lost;
    logic        rx_error;

    logic [7:0]  tx_ram_wr_addr;
    logic        tx_ram_wr_en;
    logic        tx_ram_switch;
    logic        tx_abort;
    logic [7:0]  tx_ram_rd_byte;
    logic [7:0]  tx_ram_rd_addr;
    logic        tx_ram_rd_done;
    logic        tx_en_d;

    assign int_flag     = {rx_error_flag, rx_lost_flag, ~tx_pending, rx_pending, bus_idle};
    assign irq          = |(int_flag & int_mask);
    assign tx_ram_wr_en = csr_write && (csr_address == reg_tx);
    assign tx_en        = tx_en_d && setting.f.tx_push_pull;

    always_comb begin
        case (csr_address)
            reg_version:       csr_readdata = cdbus_version;
            reg_setting:       csr_readdata = setting.raw;
            reg_idle_wait_len: csr_readdata = idle_wait_len;
            reg_tx_wait_len:   csr_readdata = tx_wait_len;
            reg_filter:        csr_readdata = filter;
            reg_div_l:         csr_readdata = div[7:0];
            reg_div_h:         csr_readdata = div[15:8];
            reg_int_flag:      csr_readdata = {3'd0, int_flag};
            reg_int_mask:      csr_readdata = {3'd0, int_mask};
            reg_rx:            csr_readdata = rx_ram_rd_byte;
            reg_rx_addr:       csr_readdata = rx_ram_rd_addr;
            default:           csr_readdata = 8'h00;
        endcase
    end

    // Line input synchronizer
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            setting.raw    <= 8'h00;
            idle_wait_len  <= 8'd10;
            tx_wait_len    <= 8'd20;
            filter         <= 8'hff;
            div            <= div_default;
            int_mask       <= 5'd0;
            rx_error_flag  <= 1'b0;
            rx_lost_flag   <= 1'b0;
            rx_ram_rd_addr <= 8'd0;
            rx_ram_rd_done <= 1'b0;
            rx_clean_all   <= 1'b0;
            tx_ram_wr_addr <= 8'd0;
            tx_ram_switch  <= 1'b0;
            tx_abort       <= 1'b0;
        end else begin
            rx_ram_rd_done <= 1'b0;
            rx_clean_all   <= 1'b0;
            tx_ram_switch  <= 1'b0;
            tx_abort       <= 1'b0;

            if (rx_error)
                rx_error_flag <= 1'b1;
            if (rx_ram_lost)
                rx_lost_flag <= 1'b1;
            if (csr_read && csr_address == reg_rx)
                rx_ram_rd_addr <= rx_ram_rd_addr + 8'd1;

            if (csr_write) begin
                case (csr_address)
                    reg_setting:       setting.raw <= csr_writedata & setting_mask;
                    reg_idle_wait_len: idle_wait_len <= csr_writedata;
                    reg_tx_wait_len:   tx_wait_len <= csr_writedata;
                    reg_filter:        filter <= csr_writedata;
                    reg_div_l:         div[7:0] <= csr_writedata;
                    reg_div_h:         div[15:8] <= csr_writedata;
                    reg_int_mask:      int_mask <= csr_writedata[4:0];
                    reg_tx:            tx_ram_wr_addr <= tx_ram_wr_addr + 8'd1;
                    reg_rx_addr:       rx_ram_rd_addr <= csr_writedata;
                    reg_rx_ctrl: begin
                        if (csr_writedata[4]) begin
                            rx_ram_rd_addr <= 8'd0;
                            rx_clean_all   <= 1'b1;
                            rx_lost_flag   <= 1'b0;
                            rx_error_flag  <= 1'b0;
                        end else begin
                            if (csr_writedata[1] || csr_writedata[0])
                                rx_ram_rd_addr <= 8'd0;
                            rx_ram_rd_done <= csr_writedata[1];
                            if (csr_writedata[2])
                                rx_lost_flag <= 1'b0;
                            if (csr_writedata[3])
                                rx_error_flag <= 1'b0;
                        end
                    end
                    reg_tx_ctrl: begin
                        if (csr_writedata[1] || csr_writedata[0])
                            tx_ram_wr_addr <= 8'd0;
                        tx_ram_switch <= csr_writedata[1] && !csr_writedata[4];
                        tx_abort      <= csr_writedata[4];
                    end
                    default: ;
                endcase
            end
        end
    end

    pp_ram #(.page_bits(rx_page_bits)) u_rx_ram (
        .clk        (clk),
        .reset_n    (reset_n),
        .wr_byte    (rx_ram_wr_byte),
        .wr_addr    (rx_ram_wr_addr),
        .wr_en      (rx_ram_wr_en),
        .switch     (rx_ram_switch),
        .rd_addr    (rx_ram_rd_addr),
        .rd_done    (rx_ram_rd_done),
        .rd_done_all(rx_clean_all),
        .rd_byte    (rx_ram_rd_byte),
        .unread     (rx_pending),
        .switch_fail(rx_ram_lost)
    );

    pp_ram #(.page_bits(tx_page_bits)) u_tx_ram (
        .clk        (clk),
        .reset_n    (reset_n),
        .wr_byte    (csr_writedata),
        .wr_addr    (tx_ram_wr_addr),
        .wr_en      (tx_ram_wr_en),
        .switch     (tx_ram_switch),
        .rd_addr    (tx_ram_rd_addr),
        .rd_done    (tx_ram_rd_done),
        .rd_done_all(1'b0),
        .rd_byte    (tx_ram_rd_byte),
        .unread     (tx_pending),
        .switch_fail()
    );

    rx_des u_rx_des (
        .clk            (clk),
        .reset_n        (reset_n),
        .div            (div),
        .idle_wait_len  (idle_wait_len),
        .rx             (rx_sync),
        .force_wait_idle(force_wait_idle),
        .data           (des_data),
        .data_clk       (des_data_clk),
        .bus_idle       (bus_idle),
        .bit_inc        (rx_bit_inc)
    );

    rx_bytes u_rx_bytes (
        .clk            (clk),
        .reset_n        (reset_n),
        .filter         (filter),
        .abort          (rx_clean_all),
        .bus_idle       (bus_idle),
        .data           (des_data),
        .data_clk       (des_data_clk),
        .ram_wr_byte    (rx_ram_wr_byte),
        .ram_wr_addr    (rx_ram_wr_addr),
        .ram_wr_en      (rx_ram_wr_en),
        .ram_switch     (rx_ram_switch),
        .error          (rx_error),
        .force_wait_idle(force_wait_idle)
    );

    tx_bytes_ser u_tx_bytes_ser (
        .clk        (clk),
        .reset_n    (reset_n),
        .div        (div),
        .tx_wait_len(tx_wait_len),
        .full_duplex(setting.f.full_duplex),
        .abort      (tx_abort),
        .bus_idle   (bus_idle),
        .rx_bit_inc (rx_bit_inc),
        .ram_unread (tx_pending),
        .ram_rd_byte(tx_ram_rd_byte),
        .ram_rd_addr(tx_ram_rd_addr),
        .ram_rd_done(tx_ram_rd_done),
        .tx         (tx),
        .tx_en      (tx_en_d)
    );

endmodule

// File: include/cdbus_tb_tasks.svh
// CDBUS testbench helpers
// Register access, line bit-banging, the frame model with its own
// CRC-16 and the value compare, included inside the testbench module
`ifndef CDBUS_TB_TASKS_SVH
`define CDBUS_TB_TASKS_SVH

task automatic check(input logic [7:0] actual, input logic [7:0] expected,
                     input string what);
    if (actual !== expected) begin
        $display("error at %0t ns: %s is 0x%0h, expected 0x%0h",
                 $time, what, actual, expected);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first mismatch");
    end
endtask

function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = $urandom;
    return r[7:0];
endfunction

// Payload length 0 to 250
function automatic logic [7:0] rand_len();
    logic [31:0] r;
    r = $urandom % 251;
    return r[7:0];
endfunction

function automatic logic accepts(input logic [7:0] dst, input logic [7:0] flt);
    return (dst == flt) || (dst == 8'hff) || (flt == 8'hff);
endfunction

// Modbus CRC over tx_q, one bit at a time
function automatic logic [15:0] frame_crc();
    logic [15:0] crc;
    logic [7:0]  d;
    logic        fb;
    int          n;
    int          b;
    crc = 16'hffff;
    for (n = 0; n < tx_q.size(); n++) begin
        d = tx_q[n];
        for (b = 0; b < 8; b++) begin
            fb  = crc[0] ^ d[b];
            crc = {1'b0, crc[15:1]};
            if (fb)
                crc = crc ^ 16'ha001;
        end
    end
    return crc;
endfunction

task automatic reg_write(input logic [4:0] addr, input logic [7:0] wdata);
    @(negedge clk);
    csr_address   = addr;
    csr_writedata = wdata;
    csr_write     = 1'b1;
    @(negedge clk);
    csr_write = 1'b0;
endtask

task automatic reg_read(input logic [4:0] addr, output logic [7:0] rdata);
    @(negedge clk);
    csr_address = addr;
    csr_read    = 1'b1;
    #1;
    rdata = csr_readdata;
    @(negedge clk);
    csr_read = 1'b0;
endtask

task automatic write_readback(input logic [4:0] addr, input string what);
    logic [7:0] v;
    logic [7:0] rd;
    v = rand_byte();
    reg_write(addr, v);
    reg_read(addr, rd);
    check(rd, v, what);
endtask

// Poll one int_flag bit until it reaches the given level
task automatic wait_flag(input int idx, input logic value);
    logic [7:0] flags;
    reg_read(reg_int_flag, flags);
    while (flags[idx] !== value)
        reg_read(reg_int_flag, flags);
endtask

task automatic make_frame(input logic [7:0] src, input logic [7:0] dst,
                          input logic [7:0] len);
    int n;
    tx_q.delete();
    tx_q.push_back(src);
    tx_q.push_back(dst);
    tx_q.push_back(len);
    for (n = 0; n < len; n++)
        tx_q.push_back(rand_byte());
    tx_crc = frame_crc();
endtask

// Stored page holds the frame followed by its two CRC bytes
task automatic expect_frame();
    int n;
    for (n = 0; n < tx_q.size(); n++)
        exp_q.push_back(tx_q[n]);
    exp_q.push_back(tx_crc[7:0]);
    exp_q.push_back(tx_crc[15:8]);
endtask

task automatic send_tx_frame();
    int n;
    wait_flag(2, 1'b1);
    reg_write(reg_tx_ctrl, 8'h01);
    for (n = 0; n < tx_q.size(); n++)
        reg_write(reg_tx, tx_q[n]);
    reg_write(reg_tx_ctrl, 8'h02);
    wait_flag(2, 1'b0);
endtask

task automatic bang_byte(input logic [7:0] b);
    logic [9:0] bits;
    int         i;
    bits = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
        bb_line = bits[i];
        repeat (test_div + 1) @(negedge clk);
    end
endtask

task automatic bang_frame(input logic corrupt);
    int n;
    @(negedge clk);
    for (n = 0; n < tx_q.size(); n++)
        bang_byte(tx_q[n]);
    bang_byte(tx_crc[7:0] ^ {7'd0, corrupt});
    bang_byte(tx_crc[15:8]);
endtask

task automatic check_page(input logic release_page);
    logic [7:0] got;
    logic [7:0] want;
    int         total;
    int         n;
    total = exp_q[2] + 5;
    reg_write(reg_rx_ctrl, 8'h01);
    for (n = 0; n < total; n++) begin
        reg_read(reg_rx, got);
        want = exp_q.pop_front();
        check(got, want, "rx page byte");
    end
    if (release_page)
        reg_write(reg_rx_ctrl, 8'h02);
endtask

`endif

// File: bench/cdbus_tb.sv
// CDBUS controller testbench
// Drives the register port, loops tx back to rx or bit-bangs the line,
// and checks received pages against a frame model
`timescale 1ns/100ps

module cdbus_tb
    import cdbus_pkg::*;
();

    localparam int test_div     = 3;
    localparam int n_frames     = 9;
    localparam int frame_cycles = (260 * 10 + 30) * (test_div + 1);
    // Divider counter may run a full wrap after div is lowered
    localparam int cycle_limit  = 2 * n_frames * frame_cycles + 65536;

    logic        clk = 1'b0;
    logic        reset_n;
    logic [4:0]  csr_address;
    logic        csr_read;
    logic        csr_write;
    logic [7:0]  csr_writedata;
    logic [7:0]  csr_readdata;
    logic        irq;
    logic        rx;
    logic        tx;
    logic        tx_en;
    logic        loopback;
    logic        bb_line;
    int          cycle_cnt;
    logic [7:0]  tx_q[$];
    logic [7:0]  exp_q[$];
    logic [15:0] tx_crc;

    always #4 clk = ~clk;

    assign rx = loopback ? tx : bb_line;

    cdbus #(
        .div_default (16'd7),
        .rx_page_bits(2),
        .tx_page_bits(1)
    ) u_dut (
        .clk          (clk),
        .reset_n      (reset_n),
        .csr_address  (csr_address),
        .csr_read     (csr_read),
        .csr_readdata (csr_readdata),
        .csr_write    (csr_write),
        .csr_writedata(csr_writedata),
        .irq          (irq),
        .rx           (rx),
        .tx           (tx),
        .tx_en        (tx_en)
    );

    `include "cdbus_tb_tasks.svh"

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("run timed out after %0d cycles without finishing", cycle_cnt);
            $display("TESTBENCH FAILED");
            $fatal(1, "timeout");
        end
    end

    // Push-pull is set for every frame, so a low line needs tx_en
    always @(negedge clk) begin
        if (reset_n === 1'b1 && tx === 1'b0)
            check({7'd0, tx_en}, 8'd1, "tx_en while tx low");
    end

    initial begin
        logic [7:0] rd;
        logic [7:0] v;
        logic [7:0] flt;
        logic [7:0] dst;
        int         n;

        void'($urandom(79285));
        reset_n       = 1'b0;
        csr_address   = 5'd0;
        csr_read      = 1'b0;
        csr_write     = 1'b0;
        csr_writedata = 8'd0;
        loopback      = 1'b0;
        bb_line       = 1'b1;
        cycle_cnt     = 0;
        repeat (8) @(negedge clk);
        reset_n = 1'b1;

        // Reset values
        check({7'd0, irq}, 8'd0, "irq after reset");
        check({7'd0, tx}, 8'd1, "tx after reset");
        check({7'd0, tx_en}, 8'd0, "tx_en after reset");
        reg_read(reg_version, rd);
        check(rd, 8'h08, "version");
        reg_read(reg_setting, rd);
        check(rd, 8'h00, "setting");
        reg_read(reg_idle_wait_len, rd);
        check(rd, 8'd10, "idle_wait_len");
        reg_read(reg_tx_wait_len, rd);
        check(rd, 8'd20, "tx_wait_len");
        reg_read(reg_filter, rd);
        check(rd, 8'hff, "filter");
        reg_read(reg_div_l, rd);
        check(rd, 8'h07, "div_l");
        reg_read(reg_div_h, rd);
        check(rd, 8'h00, "div_h");
        wait_flag(0, 1'b1);
        reg_read(reg_int_flag, rd);
        check(rd, 8'h05, "int_flag when idle");
        check({7'd0, irq}, 8'd0, "irq with mask clear");

        // Register readback
        v = rand_byte();
        reg_write(reg_setting, v);
        reg_read(reg_setting, rd);
        check(rd, v & 8'h81, "setting readback");
        write_readback(reg_idle_wait_len, "idle_wait_len readback");
        write_readback(reg_tx_wait_len, "tx_wait_len readback");
        write_readback(reg_filter, "filter readback");
        write_readback(reg_div_l, "div_l readback");
        write_readback(reg_div_h, "div_h readback");
        v = rand_byte();
        reg_write(reg_int_mask, v);
        reg_read(reg_int_mask, rd);
        check(rd, v & 8'h1f, "int_mask readback");
        check({7'd0, irq}, {7'd0, |(v[4:0] & 5'b00101)}, "irq for random mask");
        reg_write(reg_int_mask, 8'h04);
        check({7'd0, irq}, 8'd1, "irq on tx_free");
        reg_write(reg_int_mask, 8'h00);
        check({7'd0, irq}, 8'd0, "irq masked");

        reg_write(reg_setting, 8'h01);
        reg_write(reg_idle_wait_len, 8'd10);
        reg_write(reg_tx_wait_len, 8'd20);
        reg_write(reg_div_h, 8'h00);
        reg_write(reg_div_l, test_div[7:0]);

        // Loopback of one frame
        @(negedge clk);
        loopback = 1'b1;
        dst = rand_byte();
        reg_write(reg_filter, dst);
        make_frame(rand_byte(), dst, rand_len());
        expect_frame();
        reg_write(reg_int_mask, 8'h02);
        send_tx_frame();
        wait_flag(1, 1'b1);
        check({7'd0, irq}, 8'd1, "irq on rx_pending");
        wait_flag(2, 1'b1);
        check_page(1'b1);
        reg_read(reg_int_flag, rd);
        check(rd & 8'h02, 8'h00, "rx_pending after page done");
        reg_write(reg_int_mask, 8'h00);

        // Filter miss, then broadcast
        flt = rand_byte() & 8'h7f;
        dst = flt ^ 8'h01;
        reg_write(reg_filter, flt);
        make_frame(rand_byte(), dst, rand_len());
        if (accepts(dst, flt))
            expect_frame();
        send_tx_frame();
        wait_flag(2, 1'b1);
        wait_flag(0, 1'b1);
        repeat (8) @(negedge clk);
        reg_read(reg_int_flag, rd);
        check({7'd0, rd[1]}, {7'd0, accepts(dst, flt)}, "rx_pending after filter miss");
        make_frame(rand_byte(), 8'hff, rand_len());
        expect_frame();
        send_tx_frame();
        wait_flag(1, 1'b1);
        check_page(1'b1);

        // Bad CRC from the line
        @(negedge clk);
        loopback = 1'b0;
        make_frame(rand_byte(), flt, rand_len());
        bang_frame(1'b1);
        wait_flag(4, 1'b1);
        reg_read(reg_int_flag, rd);
        check(rd & 8'h02, 8'h00, "rx_pending after bad crc");
        reg_write(reg_rx_ctrl, 8'h08);
        reg_read(reg_int_flag, rd);
        check(rd & 8'h10, 8'h00, "rx_error_flag after clear");

        // Five frames into four pages
        @(negedge clk);
        loopback = 1'b1;
        for (n = 0; n < 5; n++) begin
            make_frame(rand_byte(), flt, rand_len());
            if (n < 4)
                expect_frame();
            send_tx_frame();
            wait_flag(2, 1'b1);
        end
        wait_flag(3, 1'b1);
        reg_read(reg_int_flag, rd);
        check(rd & 8'h02, 8'h02, "rx_pending with pages full");
        for (n = 0; n < 3; n++)
            check_page(1'b1);
        check_page(1'b0);
        reg_write(reg_rx_ctrl, 8'h10);
        reg_read(reg_int_flag, rd);
        check(rd & 8'h1a, 8'h00, "rx flags after clean all");

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// File: list.f
+incdir+include
hw/cdbus_pkg.sv
hw/pp_ram.sv
hw/rx_des.sv
hw/rx_bytes.sv
hw/tx_bytes_ser.sv
hw/cdbus.sv
bench/cdbus_tb.sv
